/* common/fc_params.svh */
// width and depth constants for the fully connected PE row
`ifndef FC_PARAMS_SVH
`define FC_PARAMS_SVH

// feature and weight width
`define FC_DATA_W      8

// full signed product of two operands
`define FC_PROD_W      16

// accumulator width, wraps modulo 2^28
`define FC_ACC_W       28

// processing elements in the row
`define FC_NUM_PE      4

// bits per lookahead slice
`define FC_CLA_GROUP   4

// multiplier latency in enabled cycles
`define FC_MUL_STAGES  8

`endif

/* common/fc_pkg.sv */
// shared data types for the PE row datapath
`default_nettype none

`include "fc_params.svh"

package fc_pkg;

  // signed feature or weight byte
  typedef logic signed [`FC_DATA_W-1:0] operand_t;

  // signed product out of the multiplier
  typedef logic signed [`FC_PROD_W-1:0] product_t;

  // running dot product
  typedef logic signed [`FC_ACC_W-1:0] acc_t;

  // byte k goes to element k
  typedef logic [`FC_NUM_PE*`FC_DATA_W-1:0] weight_word_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build the PE row testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

# width warnings stay visible but do not stop the build
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_pe_row

# a failing run still has its output searched below
sim_out="$(./obj_dir/Vtb_pe_row 2>&1)" || true
printf '%s\n' "$sim_out"

if grep -qF 'All tests passed!' <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

/* sim/tb_pe_row.sv */
// directed testbench for the PE row covering latency, signed sums, restart, stall and wrap
`timescale 1ns/10ps
`default_nettype none

`include "fc_params.svh"

module tb_pe_row
  import fc_pkg::*;
();

  localparam int MAC_LAT      = `FC_MUL_STAGES + 1;  // element 0 latency from inputs to result
  localparam int SETTLE_EDGES = MAC_LAT + `FC_NUM_PE;  // last element plus one edge
  localparam int LAT_TIMEOUT  = 24;
  localparam int WRAP_LEN     = 9000;                  // 9000 * 16384 > 2^27
  localparam int DOT_FEATS [16] = '{-128, 127, -1, 0, 1, 64, -64, 100,
                                    -100, 2, -2, 55, -77, 127, -128, -1};
  localparam int RESTART_FEATS [8] = '{3, -5, 7, -9, 11, -13, 15, -17};

  logic         clk;
  logic         rstn;
  logic         en;
  logic         first;
  operand_t     feat;
  weight_word_t weights;
  acc_t         result [`FC_NUM_PE];

  acc_t         exp_acc [`FC_NUM_PE];  // reference sums

  pe_row u_dut (
    .clk     (clk),
    .rstn    (rstn),
    .en      (en),
    .first   (first),
    .feat    (feat),
    .weights (weights),
    .result  (result)
  );

  always #4 clk = ~clk;  // 8 ns period

  //////////////////////////////////////////////////
  // reporting and checking
  //////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic signed [63:0] actual,
                             input logic signed [63:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL time=%0t %s actual=%0d expected=%0d",
                          $time, name, actual, expected));
    end
  endtask

  task automatic check_sums(input string tag);
    for (int k = 0; k < `FC_NUM_PE; k++) begin
      check_value($sformatf("%s result[%0d]", tag, k), result[k], exp_acc[k]);
    end
  endtask

  //////////////////////////////////////////////////
  // reference model and drivers
  //////////////////////////////////////////////////
  function automatic operand_t lane_byte(input weight_word_t w, input int k);
    return operand_t'(w[k*`FC_DATA_W +: `FC_DATA_W]);
  endfunction

  // dot product per lane wrapped to the accumulator width
  task automatic model_step(input logic first_v, input operand_t feat_v, input weight_word_t w);
    longint prod;
    for (int k = 0; k < `FC_NUM_PE; k++) begin
      prod = longint'(feat_v) * longint'(lane_byte(w, k));
      if (first_v) begin
        exp_acc[k] = acc_t'(prod);
      end else begin
        exp_acc[k] = acc_t'(longint'(exp_acc[k]) + prod);
      end
    end
  endtask

  task automatic feed(input logic first_v, input operand_t feat_v, input weight_word_t w);
    @(negedge clk);
    en      = 1'b1;
    first   = first_v;
    feat    = feat_v;
    weights = w;
    model_step(first_v, feat_v, w);
  endtask

  task automatic idle_edges(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      en      = 1'b1;
      first   = 1'b0;
      feat    = '0;
      weights = '0;
    end
  endtask

  // en low for n edges with junk on the data inputs
  task automatic stall(input int n);
    acc_t held [`FC_NUM_PE];
    @(negedge clk);
    en      = 1'b0;
    first   = 1'b1;
    feat    = operand_t'($urandom);
    weights = weight_word_t'($urandom);
    held    = result;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      for (int k = 0; k < `FC_NUM_PE; k++) begin
        check_value($sformatf("stalled result[%0d]", k), result[k], held[k]);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  task automatic test_reset();
    for (int k = 0; k < `FC_NUM_PE; k++) begin
      exp_acc[k] = '0;
    end
    check_sums("reset");
  endtask

  task automatic test_latency();
    int seen;
    int edge_n;
    feed(1'b1, operand_t'(5), 32'hFE0BF903);  // weights 3, -7, 11, -2
    seen   = 0;
    edge_n = 1;
    while (seen < `FC_NUM_PE && edge_n < LAT_TIMEOUT) begin
      idle_edges(1);  // edge_n enabled edges since the inputs were presented
      for (int k = 0; k < `FC_NUM_PE; k++) begin
        if (edge_n < MAC_LAT + k) begin
          check_value($sformatf("early result[%0d]", k), result[k], 0);
        end else if (edge_n == MAC_LAT + k) begin
          check_value($sformatf("latency result[%0d]", k), result[k], exp_acc[k]);
          seen++;
        end
      end
      edge_n++;
    end
    if (seen < `FC_NUM_PE) begin
      abort_run("timeout: not every element produced the single product in time");
    end
  endtask

  task automatic test_signed_dot();
    for (int i = 0; i < 16; i++) begin
      feed(i == 0, operand_t'(DOT_FEATS[i]), 32'h03FF7F80);  // -128, 127, -1, 3
    end
    idle_edges(SETTLE_EDGES);
    check_sums("dot");
  endtask

  // new vector must replace the old sums
  task automatic test_restart();
    for (int i = 0; i < 8; i++) begin
      feed(i == 0, operand_t'(RESTART_FEATS[i]), 32'h10F605C0);
    end
    idle_edges(SETTLE_EDGES);
    check_sums("restart");
  endtask

  task automatic test_stall();
    for (int i = 0; i < 32; i++) begin
      if (i == 8 || i == 20 || (i > 0 && ($urandom % 5) == 0)) begin
        stall(int'(1 + $urandom % 4));
      end
      feed(i == 0, operand_t'($urandom), weight_word_t'($urandom));
    end
    idle_edges(SETTLE_EDGES);
    check_sums("stall");
  endtask

  task automatic test_wrap();
    for (int i = 0; i < WRAP_LEN; i++) begin
      feed(i == 0, operand_t'(-128), 32'h80808080);
    end
    idle_edges(SETTLE_EDGES);
    check_sums("wrap");
  endtask

  initial begin
    void'($urandom(14238));
    clk      = 1'b0;
    rstn     = 1'b0;
    en       = 1'b0;
    first    = 1'b0;
    feat     = '0;
    weights  = '0;
    for (int k = 0; k < `FC_NUM_PE; k++) begin
      exp_acc[k] = '0;
    end
    repeat (10) @(negedge clk);
    rstn = 1'b1;

    test_reset();
    test_latency();  // needs an idle row
    test_signed_dot();
    test_restart();
    test_stall();
    test_wrap();

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/fc_pkg.sv
verilog/cla/cla_group.sv
verilog/cla/cla_adder.sv
verilog/pe/pe_multiplier.sv
verilog/pe/pe_mac.sv
verilog/weight_skew.sv
verilog/pe_row.sv
sim/tb_pe_row.sv

/* verilog/cla/cla_adder.sv */
// multi-slice carry-lookahead adder, wraps modulo 2^WIDTH
`timescale 1ns/10ps
`default_nettype none

`include "fc_params.svh"

module cla_adder #(
  parameter int WIDTH = 28  // multiple of the slice width
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic [WIDTH-1:0] sum
);

  localparam int NGRP = WIDTH / `FC_CLA_GROUP;

  logic [NGRP-1:0] grp_p;
  logic [NGRP-1:0] grp_g;
  logic [NGRP-1:0] grp_c;  // carry into each slice

  //////////////////////////////////////////////////
  // lookahead carry unit
  //////////////////////////////////////////////////
  // carry into slice i is any lower slice j generating a carry
  // that every slice between j and i propagates; adder carry-in is 0
  always_comb begin : lcu
    logic term;
    term = 1'b0;
    for (int i = 0; i < NGRP; i++) begin
      grp_c[i] = 1'b0;
      for (int j = 0; j < i; j++) begin
        term = grp_g[j];
        for (int m = j + 1; m < i; m++) begin
          term = term & grp_p[m];
        end
        grp_c[i] = grp_c[i] | term;
      end
    end
  end

  for (genvar gi = 0; gi < NGRP; gi++) begin : g_grp
    cla_group u_grp (
      .a        (a[gi*`FC_CLA_GROUP +: `FC_CLA_GROUP]),
      .b        (b[gi*`FC_CLA_GROUP +: `FC_CLA_GROUP]),
      .carry_in (grp_c[gi]),
      .sum      (sum[gi*`FC_CLA_GROUP +: `FC_CLA_GROUP]),
      .prop_grp (grp_p[gi]),
      .gen_grp  (grp_g[gi])
    );
  end

endmodule

`default_nettype wire

/* verilog/cla/cla_group.sv */
// carry-lookahead slice with group propagate and generate outputs
`timescale 1ns/10ps
`default_nettype none

`include "fc_params.svh"

module cla_group (
  input  logic [`FC_CLA_GROUP-1:0] a,
  input  logic [`FC_CLA_GROUP-1:0] b,
  input  logic                     carry_in,
  output logic [`FC_CLA_GROUP-1:0] sum,
  output logic                     prop_grp,
  output logic                     gen_grp
);

  logic [`FC_CLA_GROUP-1:0] prop, gen;
  logic [`FC_CLA_GROUP-1:0] carry;  // carry[0] is the slice carry-in

  assign prop = a ^ b;
  assign gen  = a & b;

  always_comb begin
    carry[0] = carry_in;
    gen_grp  = gen[0];
    for (int i = 0; i < `FC_CLA_GROUP - 1; i++) begin
      carry[i+1] = gen[i] | (prop[i] & carry[i]);
    end
    // slice generate term does not depend on carry_in
    for (int i = 1; i < `FC_CLA_GROUP; i++) begin
      gen_grp = gen[i] | (prop[i] & gen_grp);
    end
  end

  assign prop_grp = &prop;
  assign sum      = prop ^ carry;

endmodule

`default_nettype wire

/* verilog/pe/pe_mac.sv */
// processing element: multiply, accumulate, forward feature to the next element
`timescale 1ns/10ps
`default_nettype none

`include "fc_params.svh"

module pe_mac
  import fc_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     en,
  input  logic     first,
  input  operand_t feat,
  input  operand_t weight,
  output operand_t feat_out,
  output logic     first_out,
  output acc_t     result
);

  product_t product;
  logic     first_tag;
  acc_t     prod_ext;
  acc_t     addend;
  acc_t     acc_next;

  // systolic forwarding
  always_ff @(posedge clk) begin
    if (!rstn) begin
      feat_out  <= '0;
      first_out <= 1'b0;
    end else if (en) begin
      feat_out  <= feat;
      first_out <= first;
    end
  end

  pe_multiplier u_mul (
    .clk       (clk),
    .rstn      (rstn),
    .en        (en),
    .a         (feat),
    .b         (weight),
    .first_in  (first),
    .product   (product),
    .first_tag (first_tag)
  );

  assign prod_ext = {{(`FC_ACC_W-`FC_PROD_W){product[`FC_PROD_W-1]}}, product};
  assign addend   = first_tag ? '0 : result;  // new dot product starts from zero

  cla_adder #(.WIDTH(`FC_ACC_W)) u_acc_add (
    .a   (prod_ext),
    .b   (addend),
    .sum (acc_next)
  );

  always_ff @(posedge clk) begin
    if (!rstn) begin
      result <= '0;
    end else if (en) begin
      result <= acc_next;  // wraps modulo 2^28
    end
  end

endmodule

`default_nettype wire

/* verilog/pe/pe_multiplier.sv */
// eight-stage pipelined signed multiplier, magnitudes and a split-carry adder tree
`timescale 1ns/10ps
`default_nettype none

`include "fc_params.svh"

module pe_multiplier
  import fc_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     en,
  input  operand_t a,
  input  operand_t b,
  input  logic     first_in,
  output product_t product,
  output logic     first_tag
);

  logic [`FC_DATA_W-1:0] a_mag, b_mag;
  logic [`FC_DATA_W-1:0] pp_q [8];   // partial products
  logic [5:0]  lo2_q  [4];
  logic [2:0]  hi2e_q [4];
  logic [3:0]  hi2o_q [4];
  logic [4:0]  msb3   [4];
  logic [9:0]  sum3_q [4];
  logic [7:0]  lo4_q  [2];
  logic [2:0]  hi4e_q [2];
  logic [4:0]  hi4o_q [2];
  logic [4:0]  msb5   [2];
  logic [11:0] sum5_q [2];
  logic [9:0]  lo6_q;
  logic [2:0]  hi6e_q;
  logic [6:0]  hi6o_q;
  logic [6:0]  msb7;
  logic [15:0] mag_q;                     // unsigned product
  logic [`FC_MUL_STAGES-2:0] sign_q;      // product sign, stages 1..7
  logic [`FC_MUL_STAGES-1:0] tag_q;       // first marker, stages 1..8

  assign a_mag = a[7] ? ~a + 1'b1 : a;  // -128 maps to 128
  assign b_mag = b[7] ? ~b + 1'b1 : b;

  // upper halves with the carry out of the lower half
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      msb3[i] = hi2e_q[i] + hi2o_q[i] + lo2_q[i][5];
    end
    for (int j = 0; j < 2; j++) begin
      msb5[j] = hi4e_q[j] + hi4o_q[j] + lo4_q[j][7];
    end
    msb7 = hi6e_q + hi6o_q + lo6_q[9];
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      tag_q  <= '0;
      sign_q <= '0;
    end else if (en) begin
      tag_q  <= {tag_q[`FC_MUL_STAGES-2:0], first_in};
      sign_q <= {sign_q[`FC_MUL_STAGES-3:0], a[7] ^ b[7]};
    end
  end

  assign first_tag = tag_q[`FC_MUL_STAGES-1];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < 8; i++) begin
        pp_q[i] <= '0;
      end
      for (int i = 0; i < 4; i++) begin
        lo2_q[i]  <= '0;
        hi2e_q[i] <= '0;
        hi2o_q[i] <= '0;
        sum3_q[i] <= '0;
      end
      for (int j = 0; j < 2; j++) begin
        lo4_q[j]  <= '0;
        hi4e_q[j] <= '0;
        hi4o_q[j] <= '0;
        sum5_q[j] <= '0;
      end
      lo6_q   <= '0;
      hi6e_q  <= '0;
      hi6o_q  <= '0;
      mag_q   <= '0;
      product <= '0;
    end else if (en) begin
      //////////////////////////////////////////////////
      // stage 1: partial products
      //////////////////////////////////////////////////
      for (int i = 0; i < 8; i++) begin
        pp_q[i] <= b_mag[i] ? a_mag : '0;
      end
      //////////////////////////////////////////////////
      // stages 2-3: pairs, offset 1, low then high
      //////////////////////////////////////////////////
      for (int i = 0; i < 4; i++) begin
        lo2_q[i]  <= pp_q[2*i][4:0] + {pp_q[2*i+1][3:0], 1'b0};
        hi2e_q[i] <= pp_q[2*i][7:5];
        hi2o_q[i] <= pp_q[2*i+1][7:4];
        sum3_q[i] <= {msb3[i], lo2_q[i][4:0]};
      end
      //////////////////////////////////////////////////
      // stages 4-5: quads, offset 2
      //////////////////////////////////////////////////
      for (int j = 0; j < 2; j++) begin
        lo4_q[j]  <= sum3_q[2*j][6:0] + {sum3_q[2*j+1][4:0], 2'b00};
        hi4e_q[j] <= sum3_q[2*j][9:7];
        hi4o_q[j] <= sum3_q[2*j+1][9:5];
        sum5_q[j] <= {msb5[j], lo4_q[j][6:0]};
      end
      // stages 6-7: final pair, offset 4
      lo6_q  <= sum5_q[0][8:0] + {sum5_q[1][4:0], 4'b0000};
      hi6e_q <= sum5_q[0][11:9];
      hi6o_q <= sum5_q[1][11:5];
      mag_q  <= {msb7, lo6_q[8:0]};
      // stage 8: restore the sign
      product <= sign_q[`FC_MUL_STAGES-2] ? ~mag_q + 1'b1 : mag_q;
    end
  end

endmodule

`default_nettype wire

/* verilog/pe_row.sv */
// top level: systolic row of processing elements fed through the weight skew
`timescale 1ns/10ps
`default_nettype none

`include "fc_params.svh"

module pe_row
  import fc_pkg::*;
(
  input  logic         clk,
  input  logic         rstn,
  input  logic         en,
  input  logic         first,
  input  operand_t     feat,
  input  weight_word_t weights,
  output acc_t         result [`FC_NUM_PE]
);

  operand_t lane_weight [`FC_NUM_PE];
  operand_t feat_chain  [`FC_NUM_PE+1];  // entry k feeds element k
  logic     first_chain [`FC_NUM_PE+1];

  assign feat_chain[0]  = feat;
  assign first_chain[0] = first;

  weight_skew u_skew (
    .clk         (clk),
    .rstn        (rstn),
    .en          (en),
    .weights     (weights),
    .lane_weight (lane_weight)
  );

  // element k sees a feature one cycle after element k-1
  for (genvar k = 0; k < `FC_NUM_PE; k++) begin : g_pe
    pe_mac u_pe (
      .clk       (clk),
      .rstn      (rstn),
      .en        (en),
      .first     (first_chain[k]),
      .feat      (feat_chain[k]),
      .weight    (lane_weight[k]),
      .feat_out  (feat_chain[k+1]),
      .first_out (first_chain[k+1]),
      .result    (result[k])
    );
  end

endmodule

`default_nettype wire

/* verilog/weight_skew.sv */
// weight skew: delays weight byte k by k enabled cycles to meet its feature
`timescale 1ns/10ps
`default_nettype none

`include "fc_params.svh"

module weight_skew
  import fc_pkg::*;
(
  input  logic         clk,
  input  logic         rstn,
  input  logic         en,
  input  weight_word_t weights,
  output operand_t     lane_weight [`FC_NUM_PE]
);

  assign lane_weight[0] = weights[`FC_DATA_W-1:0];  // no delay for lane 0

  // lane k holds a k-deep shift register
  for (genvar k = 1; k < `FC_NUM_PE; k++) begin : g_lane
    operand_t taps_q [k];

    always_ff @(posedge clk) begin
      if (!rstn) begin
        for (int i = 0; i < k; i++) begin
          taps_q[i] <= '0;
        end
      end else if (en) begin
        taps_q[0] <= weights[k*`FC_DATA_W +: `FC_DATA_W];
        for (int i = 1; i < k; i++) begin
          taps_q[i] <= taps_q[i-1];
        end
      end
    end

    assign lane_weight[k] = taps_q[k-1];
  end

endmodule

`default_nettype wire
